// File: common/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] data_t;      // Data word or byte address
    typedef logic [31:0] instr_t;     // Raw instruction word
    typedef logic [4:0]  reg_addr_t;  // Register index

    localparam int REG_COUNT = 32;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_SLT, ALU_SLTU, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,  // Value read in decode
        FWD_MEM = 2'd1,  // ALU result now in MEM
        FWD_WB  = 2'd2   // Final writeback value
    } fwd_sel_e;

endpackage

// File: fetch/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; #(
    parameter data_t RESET_PC = 32'h0000_0000
) (
    input  logic   clock,
    input  logic   rst,
    input  logic   stall,          // Load-use hold from decode
    input  instr_t instruction,    // Word returned by instruction memory
    output data_t  fetch_address,
    output instr_t id_instruction
);

    data_t pc;

    assign fetch_address = pc;  // Memory answers in the same cycle

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= pc + 32'd4;  // Straight-line fetch only
        end
    end

    // IF/ID register
    always_ff @(posedge clock) begin
        if (rst) begin
            id_instruction <= '0;  // Zero word decodes as a no-op
        end else if (!stall) begin
            id_instruction <= instruction;
        end
    end

endmodule

// File: decode/control_decoder.sv
`timescale 1ns/1ps

module control_decoder import mips_pkg::*; (
    input  instr_t  instruction,
    output alu_op_e alu_op,
    output logic    alu_src,     // Operand B from the immediate
    output logic    sign_ext,
    output logic    dest_is_rd,
    output logic    uses_rt,     // Instruction reads rt
    output logic    mem_read,
    output logic    mem_write,
    output logic    reg_write
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instruction[31:26];
    assign funct  = instruction[5:0];

    always_comb begin
        alu_op     = ALU_ADD;  // Defaults give a no-op
        alu_src    = 1'b0;
        sign_ext   = 1'b0;
        dest_is_rd = 1'b0;
        uses_rt    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        reg_write  = 1'b0;
        unique case (opcode)
            OP_RTYPE: begin
                dest_is_rd = 1'b1;
                uses_rt    = 1'b1;
                reg_write  = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    default: begin
                        uses_rt   = 1'b0;  // Unknown funct, incl. the zero word
                        reg_write = 1'b0;
                    end
                endcase
            end
            OP_ADDIU: begin alu_src = 1'b1; sign_ext = 1'b1; reg_write = 1'b1; end
            OP_SLTI: begin
                alu_op = ALU_SLT; alu_src = 1'b1; sign_ext = 1'b1; reg_write = 1'b1;
            end
            OP_ANDI: begin alu_op = ALU_AND; alu_src = 1'b1; reg_write = 1'b1; end
            OP_ORI:  begin alu_op = ALU_OR;  alu_src = 1'b1; reg_write = 1'b1; end
            OP_XORI: begin alu_op = ALU_XOR; alu_src = 1'b1; reg_write = 1'b1; end
            OP_LUI:  begin alu_op = ALU_LUI; alu_src = 1'b1; reg_write = 1'b1; end
            OP_LW: begin
                alu_src = 1'b1; sign_ext = 1'b1; mem_read = 1'b1; reg_write = 1'b1;
            end
            OP_SW: begin
                alu_src = 1'b1; sign_ext = 1'b1; mem_write = 1'b1; uses_rt = 1'b1;
            end
            default: ;  // Unknown opcode stays a no-op
        endcase
    end

endmodule

// File: decode/register_file.sv
`timescale 1ns/1ps

module register_file import mips_pkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    output data_t     rs_value,
    output data_t     rt_value,
    input  reg_addr_t wr_addr,
    input  data_t     wr_data,
    input  logic      wr_en
);

    data_t regs [REG_COUNT];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;  // r0 is never written
        end
    end

    // Same-cycle write goes straight through to the reads
    always_comb begin
        rs_value = regs[rs];
        rt_value = regs[rt];
        if (wr_en && wr_addr != '0 && wr_addr == rs) rs_value = wr_data;
        if (wr_en && wr_addr != '0 && wr_addr == rt) rt_value = wr_data;
    end

endmodule

// File: decode/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import mips_pkg::*; (
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  logic      uses_rt,
    input  reg_addr_t ex_dest,       // Producer now in EX, in MEM next cycle
    input  logic      ex_mem_read,
    input  logic      ex_reg_write,
    input  reg_addr_t mem_dest,      // Producer now in MEM, in WB next cycle
    input  logic      mem_reg_write,
    output logic      stall,
    output fwd_sel_e  fwd_rs,
    output fwd_sel_e  fwd_rt
);

    // Selection is made one stage ahead of its use
    function automatic fwd_sel_e pick_source(
        reg_addr_t src,
        reg_addr_t near_dest,
        logic      near_write,
        reg_addr_t far_dest,
        logic      far_write
    );
        if (src == '0) return FWD_REG;  // r0 is constant
        if (near_write && near_dest == src) return FWD_MEM;  // Nearer stage first
        if (far_write && far_dest == src) return FWD_WB;
        return FWD_REG;
    endfunction

    assign fwd_rs = pick_source(rs, ex_dest, ex_reg_write, mem_dest, mem_reg_write);
    assign fwd_rt = uses_rt ? pick_source(rt, ex_dest, ex_reg_write, mem_dest, mem_reg_write)
                            : FWD_REG;

    // Load data only exists after MEM, so a dependent op waits one cycle
    assign stall = ex_mem_read && ex_dest != '0 &&
                   (ex_dest == rs || (uses_rt && ex_dest == rt));

endmodule

// File: decode/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  instr_t    id_instruction,
    input  reg_addr_t mem_dest,
    input  logic      mem_reg_write,
    input  reg_addr_t wb_dest,
    input  data_t     wb_data,
    input  logic      wb_reg_write,
    output logic      stall,
    output data_t     ex_rs_value,
    output data_t     ex_rt_value,
    output data_t     ex_imm,
    output alu_op_e   ex_alu_op,
    output logic      ex_alu_src,
    output fwd_sel_e  ex_fwd_rs,
    output fwd_sel_e  ex_fwd_rt,
    output reg_addr_t ex_dest,
    output logic      ex_mem_read,
    output logic      ex_mem_write,
    output logic      ex_reg_write
);

    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    data_t     rs_value;
    data_t     rt_value;
    data_t     imm;
    alu_op_e   alu_op;
    logic      alu_src;
    logic      sign_ext;
    logic      dest_is_rd;
    logic      uses_rt;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    fwd_sel_e  fwd_rs;
    fwd_sel_e  fwd_rt;

    assign rs = id_instruction[25:21];
    assign rt = id_instruction[20:16];
    assign rd = id_instruction[15:11];

    // Logical immediates are zero extended
    assign imm = sign_ext ? {{16{id_instruction[15]}}, id_instruction[15:0]}
                          : {16'h0000, id_instruction[15:0]};

    control_decoder u_control (
        .instruction (id_instruction),
        .alu_op      (alu_op),
        .alu_src     (alu_src),
        .sign_ext    (sign_ext),
        .dest_is_rd  (dest_is_rd),
        .uses_rt     (uses_rt),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .reg_write   (reg_write)
    );

    register_file u_regs (
        .clock    (clock),
        .rst      (rst),
        .rs       (rs),
        .rt       (rt),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .wr_addr  (wb_dest),
        .wr_data  (wb_data),
        .wr_en    (wb_reg_write)
    );

    hazard_unit u_hazard (
        .rs            (rs),
        .rt            (rt),
        .uses_rt       (uses_rt),
        .ex_dest       (ex_dest),
        .ex_mem_read   (ex_mem_read),
        .ex_reg_write  (ex_reg_write),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .stall         (stall),
        .fwd_rs        (fwd_rs),
        .fwd_rt        (fwd_rt)
    );

    // ID/EX control, a stall sends a bubble
    always_ff @(posedge clock) begin
        if (rst || stall) begin
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end else begin
            ex_mem_read  <= mem_read;
            ex_mem_write <= mem_write;
            ex_reg_write <= reg_write;
        end
    end

    // ID/EX payload
    always_ff @(posedge clock) begin
        ex_rs_value <= rs_value;
        ex_rt_value <= rt_value;
        ex_imm      <= imm;
        ex_alu_op   <= alu_op;
        ex_alu_src  <= alu_src;
        ex_fwd_rs   <= fwd_rs;
        ex_fwd_rt   <= fwd_rt;
        ex_dest     <= dest_is_rd ? rd : rt;  // rd for R-type, rt otherwise
    end

endmodule

// File: execute/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  data_t     ex_rs_value,
    input  data_t     ex_rt_value,
    input  data_t     ex_imm,
    input  alu_op_e   ex_alu_op,
    input  logic      ex_alu_src,
    input  fwd_sel_e  ex_fwd_rs,
    input  fwd_sel_e  ex_fwd_rt,
    input  reg_addr_t ex_dest,
    input  logic      ex_mem_read,
    input  logic      ex_mem_write,
    input  logic      ex_reg_write,
    input  data_t     wb_data,          // Final value in WB
    output data_t     mem_alu_result,   // Also the MEM forwarding source
    output data_t     mem_store_value,
    output reg_addr_t mem_dest,
    output logic      mem_read,
    output logic      mem_write,
    output logic      mem_reg_write
);

    data_t op_a;
    data_t rt_fwd;
    data_t op_b;
    data_t alu_result;

    function automatic data_t fwd_mux(
        fwd_sel_e sel,
        data_t    reg_value,
        data_t    mem_value,
        data_t    wb_value
    );
        case (sel)
            FWD_MEM: return mem_value;
            FWD_WB:  return wb_value;
            default: return reg_value;
        endcase
    endfunction

    assign op_a   = fwd_mux(ex_fwd_rs, ex_rs_value, mem_alu_result, wb_data);
    assign rt_fwd = fwd_mux(ex_fwd_rt, ex_rt_value, mem_alu_result, wb_data);  // Store data too
    assign op_b   = ex_alu_src ? ex_imm : rt_fwd;

    always_comb begin
        case (ex_alu_op)
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_NOR:  alu_result = ~(op_a | op_b);
            ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'b0, op_a < op_b};
            ALU_LUI:  alu_result = {op_b[15:0], 16'h0000};
            default:  alu_result = op_a + op_b;  // ADDU, ADDIU and address calc
        endcase
    end

    // EX/MEM control
    always_ff @(posedge clock) begin
        if (rst) begin
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
            mem_reg_write <= 1'b0;
        end else begin
            mem_read      <= ex_mem_read;
            mem_write     <= ex_mem_write;
            mem_reg_write <= ex_reg_write;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clock) begin
        mem_alu_result  <= alu_result;
        mem_store_value <= rt_fwd;
        mem_dest        <= ex_dest;
    end

endmodule

// File: logic/memory_writeback.sv
`timescale 1ns/1ps

module memory_writeback import mips_pkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  data_t     mem_alu_result,
    input  data_t     mem_store_value,
    input  reg_addr_t mem_dest,
    input  logic      mem_read,
    input  logic      mem_write,
    input  logic      mem_reg_write,
    input  data_t     read_data,       // Same-cycle answer from data memory
    output data_t     data_address,
    output logic      data_read,
    output logic      data_write,
    output data_t     write_data,
    output reg_addr_t wb_dest,
    output data_t     wb_data,
    output logic      wb_reg_write
);

    assign data_address = mem_alu_result;  // Address computed in EX
    assign data_read    = mem_read;
    assign data_write   = mem_write;
    assign write_data   = mem_store_value;

    always_ff @(posedge clock) begin
        if (rst) wb_reg_write <= 1'b0;
        else     wb_reg_write <= mem_reg_write;
    end

    // Select before the register so WB holds the final value
    always_ff @(posedge clock) begin
        wb_dest <= mem_dest;
        wb_data <= mem_read ? read_data : mem_alu_result;
    end

endmodule

// File: logic/mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_pkg::*; #(
    parameter data_t RESET_PC = 32'h0000_0000
) (
    input  logic   clock,
    input  logic   rst,
    output data_t  fetch_address,
    input  instr_t instruction,
    output data_t  data_address,
    output logic   data_read,
    output logic   data_write,
    output data_t  write_data,
    input  data_t  read_data
);

    logic      stall;
    instr_t    id_instruction;
    data_t     ex_rs_value;
    data_t     ex_rt_value;
    data_t     ex_imm;
    alu_op_e   ex_alu_op;
    logic      ex_alu_src;
    fwd_sel_e  ex_fwd_rs;
    fwd_sel_e  ex_fwd_rt;
    reg_addr_t ex_dest;
    logic      ex_mem_read;
    logic      ex_mem_write;
    logic      ex_reg_write;
    data_t     mem_alu_result;
    data_t     mem_store_value;
    reg_addr_t mem_dest;
    logic      mem_read;
    logic      mem_write;
    logic      mem_reg_write;
    reg_addr_t wb_dest;
    data_t     wb_data;
    logic      wb_reg_write;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clock          (clock),
        .rst            (rst),
        .stall          (stall),
        .instruction    (instruction),
        .fetch_address  (fetch_address),
        .id_instruction (id_instruction)
    );

    decode_stage u_decode (
        .clock          (clock),
        .rst            (rst),
        .id_instruction (id_instruction),
        .mem_dest       (mem_dest),
        .mem_reg_write  (mem_reg_write),
        .wb_dest        (wb_dest),
        .wb_data        (wb_data),
        .wb_reg_write   (wb_reg_write),
        .stall          (stall),
        .ex_rs_value    (ex_rs_value),
        .ex_rt_value    (ex_rt_value),
        .ex_imm         (ex_imm),
        .ex_alu_op      (ex_alu_op),
        .ex_alu_src     (ex_alu_src),
        .ex_fwd_rs      (ex_fwd_rs),
        .ex_fwd_rt      (ex_fwd_rt),
        .ex_dest        (ex_dest),
        .ex_mem_read    (ex_mem_read),
        .ex_mem_write   (ex_mem_write),
        .ex_reg_write   (ex_reg_write)
    );

    execute_stage u_execute (
        .clock           (clock),
        .rst             (rst),
        .ex_rs_value     (ex_rs_value),
        .ex_rt_value     (ex_rt_value),
        .ex_imm          (ex_imm),
        .ex_alu_op       (ex_alu_op),
        .ex_alu_src      (ex_alu_src),
        .ex_fwd_rs       (ex_fwd_rs),
        .ex_fwd_rt       (ex_fwd_rt),
        .ex_dest         (ex_dest),
        .ex_mem_read     (ex_mem_read),
        .ex_mem_write    (ex_mem_write),
        .ex_reg_write    (ex_reg_write),
        .wb_data         (wb_data),
        .mem_alu_result  (mem_alu_result),
        .mem_store_value (mem_store_value),
        .mem_dest        (mem_dest),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_reg_write   (mem_reg_write)
    );

    memory_writeback u_mem_wb (
        .clock           (clock),
        .rst             (rst),
        .mem_alu_result  (mem_alu_result),
        .mem_store_value (mem_store_value),
        .mem_dest        (mem_dest),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_reg_write   (mem_reg_write),
        .read_data       (read_data),
        .data_address    (data_address),
        .data_read       (data_read),
        .data_write      (data_write),
        .write_data      (write_data),
        .wb_dest         (wb_dest),
        .wb_data         (wb_data),
        .wb_reg_write    (wb_reg_write)
    );

endmodule

// File: testbench/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*; ();

    localparam int PROG_LEN      = 60;
    localparam int IMEM_DEPTH    = 256;
    localparam int DMEM_DEPTH    = 64;
    localparam int DUMP_BASE     = 56;    // r1..r7 land in words 57..63
    localparam int STORE_TIMEOUT = 2000;  // Cycles allowed for all stores

    logic   clock;
    logic   rst;
    data_t  fetch_address;
    instr_t instruction;
    data_t  data_address;
    logic   data_read;
    logic   data_write;
    data_t  write_data;
    data_t  read_data;

    instr_t imem [IMEM_DEPTH];
    data_t  dmem [DMEM_DEPTH];
    data_t  model_mem [DMEM_DEPTH];
    data_t  model_regs [REG_COUNT];
    data_t  store_addr_q [$];  // Expected stores in program order
    data_t  store_data_q [$];
    data_t  load_addr_q [$];

    integer seed = 32'h9c47;
    int     error_count = 0;
    int     check_count = 0;
    int     stores_seen = 0;
    int     store_total = 0;
    int     wait_cycles = 0;
    logic   monitor_on = 1'b0;
    data_t  prev_fetch;
    data_t  exp_addr;
    data_t  exp_data;

    mips_core #(.RESET_PC(32'h0000_0000)) u_dut (
        .clock         (clock),
        .rst           (rst),
        .fetch_address (fetch_address),
        .instruction   (instruction),
        .data_address  (data_address),
        .data_read     (data_read),
        .data_write    (data_write),
        .write_data    (write_data),
        .read_data     (read_data)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;  // 8 ns period
    end

    function automatic int random_below(int n);
        return {$random(seed)} % n;
    endfunction

    function automatic logic [15:0] word_offset();
        return 16'(random_below(DMEM_DEPTH) * 4);  // Aligned, from r0
    endfunction

    function automatic instr_t rtype_word(logic [5:0] funct, int rs, int rt, int rd);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic instr_t itype_word(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic instr_t random_instr();
        int         kind;
        logic [5:0] funct;
        logic [5:0] op;
        kind  = random_below(16);
        funct = FN_ADDU;
        op    = OP_ADDIU;
        case (kind)
            1:  funct = FN_SUBU;
            2:  funct = FN_AND;
            3:  funct = FN_OR;
            4:  funct = FN_XOR;
            5:  funct = FN_NOR;
            6:  funct = FN_SLT;
            7:  funct = FN_SLTU;
            9:  op = OP_SLTI;
            10: op = OP_ANDI;
            11: op = OP_ORI;
            12: op = OP_XORI;
            13: op = OP_LUI;
            default: ;
        endcase
        if (kind < 8) return rtype_word(funct, random_below(8), random_below(8), random_below(8));
        if (kind < 14) return itype_word(op, random_below(8), random_below(8), 16'($random(seed)));
        if (kind == 14) return itype_word(OP_LW, 0, random_below(7) + 1, word_offset());
        return itype_word(OP_SW, 0, random_below(8), word_offset());
    endfunction

    task automatic build_program();
        int i;
        int r;
        i = 0;
        while (i < PROG_LEN) begin
            r = random_below(7) + 1;
            if (i % 10 == 1) begin  // Load then store of the same register
                imem[i]     = itype_word(OP_LW, 0, r, word_offset());
                imem[i + 1] = itype_word(OP_SW, 0, r, word_offset());
                i += 2;
            end else if (i % 10 == 4) begin  // Load then ALU use
                imem[i]     = itype_word(OP_LW, 0, r, word_offset());
                imem[i + 1] = rtype_word(FN_ADDU, r, random_below(8), random_below(7) + 1);
                i += 2;
            end else if (i % 10 == 8) begin  // Back-to-back ALU pair
                imem[i]     = itype_word(OP_ADDIU, random_below(8), r, 16'($random(seed)));
                imem[i + 1] = rtype_word(FN_SUBU, random_below(8), r, random_below(7) + 1);
                i += 2;
            end else begin
                imem[i] = random_instr();
                i++;
            end
        end
        for (int k = 1; k < 8; k++) begin
            imem[PROG_LEN + k - 1] = itype_word(OP_SW, 0, k, 16'((DUMP_BASE + k) * 4));
        end
    endtask

    // Sequential ISA model, one instruction at a time
    task automatic run_model();
        instr_t    w;
        data_t     a;
        data_t     b;
        data_t     simm;
        data_t     zimm;
        data_t     addr;
        data_t     result;
        reg_addr_t dest;
        logic      writes;
        for (int i = 0; i < REG_COUNT; i++) model_regs[i] = '0;
        for (int pc = 0; pc < PROG_LEN + 7; pc++) begin
            w      = imem[pc];
            a      = model_regs[w[25:21]];
            b      = model_regs[w[20:16]];
            simm   = {{16{w[15]}}, w[15:0]};
            zimm   = {16'h0000, w[15:0]};
            addr   = a + simm;
            dest   = w[20:16];  // rt unless R-type
            writes = 1'b1;
            result = '0;
            case (w[31:26])
                OP_RTYPE: begin
                    dest = w[15:11];
                    case (w[5:0])
                        FN_ADDU: result = a + b;
                        FN_SUBU: result = a - b;
                        FN_AND:  result = a & b;
                        FN_OR:   result = a | b;
                        FN_XOR:  result = a ^ b;
                        FN_NOR:  result = ~(a | b);
                        FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLTU: result = (a < b) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;  // Zero word and unknown funct
                    endcase
                end
                OP_ADDIU: result = a + simm;
                OP_SLTI:  result = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                OP_ANDI:  result = a & zimm;
                OP_ORI:   result = a | zimm;
                OP_XORI:  result = a ^ zimm;
                OP_LUI:   result = {w[15:0], 16'h0000};
                OP_LW: begin
                    load_addr_q.push_back(addr);
                    result = model_mem[addr[7:2]];
                end
                OP_SW: begin
                    writes = 1'b0;
                    store_addr_q.push_back(addr);
                    store_data_q.push_back(b);
                    model_mem[addr[7:2]] = b;
                end
                default: writes = 1'b0;
            endcase
            if (writes && dest != '0) model_regs[dest] = result;  // r0 stays zero
        end
    endtask

    // Same-cycle memory answers, driven just after the edge
    always @(posedge clock) begin
        #1;
        instruction = (fetch_address < IMEM_DEPTH * 4) ? imem[fetch_address[9:2]] : '0;
        read_data   = data_read ? dmem[data_address[7:2]] : '0;
    end

    // Bus monitor on the falling edge, where outputs are stable
    always @(negedge clock) begin
        if (monitor_on) begin
            check_count++;
            assert (fetch_address == prev_fetch || fetch_address == prev_fetch + 32'd4) else begin
                $display("[ERROR] fetch_address: previous %h, got %h", prev_fetch, fetch_address);
                error_count++;
            end
            prev_fetch = fetch_address;
            check_count++;
            assert (!(data_read && data_write)) else begin
                $display("Data read and data write were high in the same cycle");
                error_count++;
            end
            if (data_write) begin
                check_count++;
                assert (store_addr_q.size() > 0) else begin
                    $display("A store to %h came after all expected stores", data_address);
                    error_count++;
                end
                if (store_addr_q.size() > 0) begin
                    exp_addr = store_addr_q.pop_front();
                    exp_data = store_data_q.pop_front();
                    stores_seen++;
                    check_count += 2;
                    assert (data_address == exp_addr) else begin
                        $display("[ERROR] data_address: expected %h, got %h",
                                 exp_addr, data_address);
                        error_count++;
                    end
                    assert (write_data == exp_data) else begin
                        $display("[ERROR] write_data: expected %h, got %h",
                                 exp_data, write_data);
                        error_count++;
                    end
                end
                dmem[data_address[7:2]] = write_data;  // Visible to the next load
            end
            if (data_read) begin
                check_count++;
                assert (load_addr_q.size() > 0) else begin
                    $display("A load from %h came after all expected loads", data_address);
                    error_count++;
                end
                if (load_addr_q.size() > 0) begin
                    exp_addr = load_addr_q.pop_front();
                    check_count++;
                    assert (data_address == exp_addr) else begin
                        $display("[ERROR] data_address: expected %h, got %h",
                                 exp_addr, data_address);
                        error_count++;
                    end
                end
            end
        end
    end

    initial begin
        rst         = 1'b1;
        instruction = '0;
        read_data   = '0;
        for (int i = 0; i < IMEM_DEPTH; i++) imem[i] = '0;
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i]      = 32'ha5c3_0000 ^ (32'(i) * 32'h0001_0107);  // Unique per word
            model_mem[i] = dmem[i];
        end
        build_program();
        run_model();
        store_total = store_addr_q.size();

        repeat (3) @(posedge clock);
        #1 rst = 1'b0;
        prev_fetch = 32'h0000_0000;
        monitor_on = 1'b1;

        @(negedge clock);
        check_count++;
        assert (fetch_address == 32'h0000_0000 && !data_read && !data_write) else begin
            $display("[ERROR] after reset: fetch_address %h, data_read %h, data_write %h",
                     fetch_address, data_read, data_write);
            error_count++;
        end

        while (stores_seen < store_total && wait_cycles < STORE_TIMEOUT) begin
            @(posedge clock);
            wait_cycles++;
        end
        check_count++;
        assert (stores_seen == store_total) else begin
            $display("Stores did not complete: %0d of %0d seen after %0d cycles",
                     stores_seen, store_total, wait_cycles);
            error_count++;
        end

        repeat (20) @(posedge clock);  // Monitor flags any extra store
        monitor_on = 1'b0;

        for (int i = 0; i < DMEM_DEPTH; i++) begin
            check_count++;
            assert (dmem[i] == model_mem[i]) else begin
                $display("[ERROR] dmem[%0d]: expected %h, got %h", i, model_mem[i], dmem[i]);
                error_count++;
            end
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
common/mips_pkg.sv
fetch/fetch_stage.sv
decode/control_decoder.sv
decode/register_file.sv
decode/hazard_unit.sv
decode/decode_stage.sv
execute/execute_stage.sv
logic/memory_writeback.sv
logic/mips_core.sv
testbench/tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - common/mips_pkg.sv
  - fetch/fetch_stage.sv
  - decode/control_decoder.sv
  - decode/register_file.sv
  - decode/hazard_unit.sv
  - decode/decode_stage.sv
  - execute/execute_stage.sv
  - logic/memory_writeback.sv
  - logic/mips_core.sv
  - target: test
    files:
      - testbench/tb_mips_core.sv
